// File: verilog/rv_core_cfg.svh
////////////////////////////////////////////////////////////////////////////
// Core width settings
// Word width, register address width and register count
////////////////////////////////////////////////////////////////////////////

`ifndef RV_CORE_CFG_SVH
`define RV_CORE_CFG_SVH

// Data word width
`define RV_XLEN 32

// Register address width
`define RV_REG_BITS 5

// Architectural integer registers
`define RV_NUM_REGS 32

`endif

// File: verilog/rv_core_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Shared core types
// Instruction word union, opcode and ALU operation enums
////////////////////////////////////////////////////////////////////////////

`default_nettype none

`include "rv_core_cfg.svh"

package rv_core_pkg;

	// Major opcodes handled by the core
	typedef enum logic [6:0] {
		OPC_OP     = 7'b0110011,	// Register-register ALU group
		OPC_OP_IMM = 7'b0010011,	// Register-immediate ALU group
		OPC_LUI    = 7'b0110111	// Load upper immediate
	} opcode_e;

	// ALU operation select
	typedef enum logic [3:0] {
		ALU_ADD    = 4'd0,
		ALU_SUB    = 4'd1,
		ALU_SLL    = 4'd2,
		ALU_SLT    = 4'd3,	// Signed compare
		ALU_SLTU   = 4'd4,	// Unsigned compare
		ALU_XOR    = 4'd5,
		ALU_SRL    = 4'd6,
		ALU_SRA    = 4'd7,	// Arithmetic right shift
		ALU_OR     = 4'd8,
		ALU_AND    = 4'd9,
		ALU_PASS_B = 4'd10	// Operand B straight through for LUI
	} alu_op_e;

	// One instruction word seen as R, I or U format
	typedef union packed {
		struct packed {
			logic [6:0]              funct7;	// Bit 5 picks SUB and SRA
			logic [`RV_REG_BITS-1:0] rs2;
			logic [`RV_REG_BITS-1:0] rs1;
			logic [2:0]              funct3;
			logic [`RV_REG_BITS-1:0] rd;
			logic [6:0]              opcode;
		} r_fmt;
		struct packed {
			logic [11:0]             imm12;	// Sign extended in ID
			logic [`RV_REG_BITS-1:0] rs1;
			logic [2:0]              funct3;
			logic [`RV_REG_BITS-1:0] rd;
			logic [6:0]              opcode;
		} i_fmt;
		struct packed {
			logic [19:0]             imm20;	// Upper immediate bits
			logic [`RV_REG_BITS-1:0] rd;
			logic [6:0]              opcode;
		} u_fmt;
	} rv_inst_t;

endpackage

`default_nettype wire

// File: verilog/decoder.sv
////////////////////////////////////////////////////////////////////////////
// ID stage decoder
// Register numbers, immediate, ALU operation and write enable
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "rv_core_cfg.svh"

module decoder import rv_core_pkg::*; (
	input  wire rv_inst_t              id_inst,	// Instruction in ID
	input  wire                        id_valid,	// ID slot holds a real instruction
	output logic [`RV_REG_BITS-1:0]    rs1,
	output logic [`RV_REG_BITS-1:0]    rs2,
	output logic [`RV_REG_BITS-1:0]    rd,
	output logic [`RV_XLEN-1:0]        imm,	// Extended immediate
	output logic                       sel_imm,	// Operand B from immediate
	output alu_op_e                    alu_op,
	output logic                       wr_en	// Valid, supported and rd not x0
);

	logic supported;	// Opcode in the kept set

	// Register fields sit at the same bits in every format
	assign rs1 = id_inst.r_fmt.rs1;
	assign rs2 = id_inst.r_fmt.rs2;
	assign rd  = id_inst.r_fmt.rd;

	always_comb begin
		supported = 1'b0;
		sel_imm   = 1'b0;
		imm       = '0;
		alu_op    = ALU_ADD;
		case (id_inst.r_fmt.opcode)
			OPC_OP: begin
				supported = 1'b1;
				// funct7 bit 5 only matters for ADD/SUB and SRL/SRA
				case (id_inst.r_fmt.funct3)
					3'b000: alu_op = id_inst.r_fmt.funct7[5] ? ALU_SUB : ALU_ADD;
					3'b001: alu_op = ALU_SLL;
					3'b010: alu_op = ALU_SLT;
					3'b011: alu_op = ALU_SLTU;
					3'b100: alu_op = ALU_XOR;
					3'b101: alu_op = id_inst.r_fmt.funct7[5] ? ALU_SRA : ALU_SRL;
					3'b110: alu_op = ALU_OR;
					default: alu_op = ALU_AND;
				endcase
			end
			OPC_OP_IMM: begin
				supported = 1'b1;
				sel_imm   = 1'b1;
				imm       = {{(`RV_XLEN-12){id_inst.i_fmt.imm12[11]}}, id_inst.i_fmt.imm12};
				// No SUBI; imm12 bit 10 is the SRAI marker
				case (id_inst.i_fmt.funct3)
					3'b000: alu_op = ALU_ADD;
					3'b001: alu_op = ALU_SLL;	// Shamt in low bits of imm
					3'b010: alu_op = ALU_SLT;
					3'b011: alu_op = ALU_SLTU;
					3'b100: alu_op = ALU_XOR;
					3'b101: alu_op = id_inst.i_fmt.imm12[10] ? ALU_SRA : ALU_SRL;
					3'b110: alu_op = ALU_OR;
					default: alu_op = ALU_AND;
				endcase
			end
			OPC_LUI: begin
				supported = 1'b1;
				sel_imm   = 1'b1;
				imm       = {id_inst.u_fmt.imm20, {(`RV_XLEN-20){1'b0}}};	// imm20 << 12
				alu_op    = ALU_PASS_B;
			end
			default: begin
				supported = 1'b0;	// Travels on as a bubble
			end
		endcase
	end

	// Single point where x0 is filtered out
	assign wr_en = id_valid && supported && (rd != '0);

endmodule

`default_nettype wire

// File: verilog/regfile.sv
////////////////////////////////////////////////////////////////////////////
// Integer register file
// Two combinational read ports, one clocked write port
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "rv_core_cfg.svh"

module regfile (
	input  wire                     clk,
	input  wire                     arst_n,
	input  wire [`RV_REG_BITS-1:0]  rs1,	// Read address A
	input  wire [`RV_REG_BITS-1:0]  rs2,	// Read address B
	input  wire                     wr_en,	// Never set for x0
	input  wire [`RV_REG_BITS-1:0]  wr_addr,
	input  wire [`RV_XLEN-1:0]      wr_data,
	output logic [`RV_XLEN-1:0]     rd_data1,
	output logic [`RV_XLEN-1:0]     rd_data2
);

	logic [`RV_XLEN-1:0] regs [`RV_NUM_REGS];

	// x0 stays at its reset value of zero
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < `RV_NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en) begin
			regs[wr_addr] <= wr_data;
		end
	end

	// Same cycle write is seen through WB forwarding
	assign rd_data1 = regs[rs1];
	assign rd_data2 = regs[rs2];

endmodule

`default_nettype wire

// File: verilog/forward_unit.sv
////////////////////////////////////////////////////////////////////////////
// Operand forwarding for the ID stage
// Youngest in-flight result wins over the register file
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "rv_core_cfg.svh"

module forward_unit (
	input  wire [`RV_REG_BITS-1:0] rs1,
	input  wire [`RV_REG_BITS-1:0] rs2,
	input  wire [`RV_XLEN-1:0]     rf_data1,	// Register file port A
	input  wire [`RV_XLEN-1:0]     rf_data2,	// Register file port B
	input  wire [`RV_XLEN-1:0]     imm,
	input  wire                    sel_imm,
	input  wire [`RV_REG_BITS-1:0] exe_rd,
	input  wire                    exe_wr_en,
	input  wire [`RV_XLEN-1:0]     exe_result,	// ALU output this cycle
	input  wire [`RV_REG_BITS-1:0] mem_rd,
	input  wire                    mem_wr_en,
	input  wire [`RV_XLEN-1:0]     mem_result,
	input  wire [`RV_REG_BITS-1:0] wb_rd,
	input  wire                    wb_wr_en,
	input  wire [`RV_XLEN-1:0]     wb_result,	// Not yet in the register file
	output logic [`RV_XLEN-1:0]    op_a,
	output logic [`RV_XLEN-1:0]    op_b
);

	// Hit flags per source and stage
	logic a_exe_hit, a_mem_hit, a_wb_hit;
	logic b_exe_hit, b_mem_hit, b_wb_hit;

	// wr_en is already low for x0 and bubbles
	assign a_exe_hit = exe_wr_en && (exe_rd == rs1);
	assign a_mem_hit = mem_wr_en && (mem_rd == rs1);
	assign a_wb_hit  = wb_wr_en && (wb_rd == rs1);

	assign b_exe_hit = exe_wr_en && (exe_rd == rs2);
	assign b_mem_hit = mem_wr_en && (mem_rd == rs2);
	assign b_wb_hit  = wb_wr_en && (wb_rd == rs2);

	// Operand A priority EXE then MEM then WB
	always_comb begin
		if (a_exe_hit) begin
			op_a = exe_result;
		end else if (a_mem_hit) begin
			op_a = mem_result;
		end else if (a_wb_hit) begin
			op_a = wb_result;
		end else begin
			op_a = rf_data1;
		end
	end

	// Operand B with the immediate taking over for OP-IMM and LUI
	always_comb begin
		if (sel_imm) begin
			op_b = imm;
		end else if (b_exe_hit) begin
			op_b = exe_result;
		end else if (b_mem_hit) begin
			op_b = mem_result;
		end else if (b_wb_hit) begin
			op_b = wb_result;
		end else begin
			op_b = rf_data2;
		end
	end

endmodule

`default_nettype wire

// File: verilog/alu.sv
////////////////////////////////////////////////////////////////////////////
// Integer ALU
// Add, subtract, logic, compares and shifts
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "rv_core_cfg.svh"

module alu import rv_core_pkg::*; (
	input  wire [`RV_XLEN-1:0] op_a,
	input  wire [`RV_XLEN-1:0] op_b,	// Register or immediate
	input  wire alu_op_e       alu_op,
	output logic [`RV_XLEN-1:0] result
);

	logic [4:0] shamt;	// RV32 shift amount
	logic       lt_signed;
	logic       lt_unsigned;

	assign shamt       = op_b[4:0];
	assign lt_signed   = $signed(op_a) < $signed(op_b);
	assign lt_unsigned = op_a < op_b;

	always_comb begin
		case (alu_op)
			ALU_ADD:    result = op_a + op_b;
			ALU_SUB:    result = op_a - op_b;
			ALU_SLL:    result = op_a << shamt;
			ALU_SLT:    result = {{(`RV_XLEN-1){1'b0}}, lt_signed};
			ALU_SLTU:   result = {{(`RV_XLEN-1){1'b0}}, lt_unsigned};
			ALU_XOR:    result = op_a ^ op_b;
			ALU_SRL:    result = op_a >> shamt;
			ALU_SRA:    result = $signed(op_a) >>> shamt;	// Sign fill
			ALU_OR:     result = op_a | op_b;
			ALU_AND:    result = op_a & op_b;
			ALU_PASS_B: result = op_b;	// LUI
			default:    result = '0;
		endcase
	end

endmodule

`default_nettype wire

// File: verilog/stage_regs.sv
////////////////////////////////////////////////////////////////////////////
// Pipeline registers
// Input, ID/EXE, EXE/MEM and MEM/WB
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "rv_core_cfg.svh"

module stage_regs import rv_core_pkg::*; (
	input  wire                     clk,
	input  wire                     arst_n,
	input  wire                     inst_valid,	// One strobe per instruction
	input  wire rv_inst_t           inst,
	input  wire [`RV_REG_BITS-1:0]  id_rd,
	input  wire                     id_wr_en,
	input  wire alu_op_e            id_alu_op,
	input  wire [`RV_XLEN-1:0]      id_op_a,	// Forwarded operands
	input  wire [`RV_XLEN-1:0]      id_op_b,
	input  wire [`RV_XLEN-1:0]      exe_result,
	output rv_inst_t                id_inst,
	output logic                    id_valid,
	output alu_op_e                 exe_alu_op,
	output logic [`RV_XLEN-1:0]     exe_op_a,
	output logic [`RV_XLEN-1:0]     exe_op_b,
	output logic [`RV_REG_BITS-1:0] exe_rd,
	output logic                    exe_wr_en,
	output logic [`RV_REG_BITS-1:0] mem_rd,
	output logic                    mem_wr_en,
	output logic [`RV_XLEN-1:0]     mem_result,
	output logic [`RV_REG_BITS-1:0] wb_rd,
	output logic                    wb_wr_en,	// Also the core writeback strobe
	output logic [`RV_XLEN-1:0]     wb_result
);

	////////////////////////////////////////////////////////////////////////////
	// Input register in front of ID
	////////////////////////////////////////////////////////////////////////////

	// Idle cycle leaves id_valid low and becomes a bubble
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			id_valid <= 1'b0;
			id_inst  <= '0;
		end else begin
			id_valid <= inst_valid;
			id_inst  <= inst;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// ID/EXE
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			exe_alu_op <= ALU_ADD;
			exe_op_a   <= '0;
			exe_op_b   <= '0;
			exe_rd     <= '0;
			exe_wr_en  <= 1'b0;
		end else begin
			exe_alu_op <= id_alu_op;
			exe_op_a   <= id_op_a;
			exe_op_b   <= id_op_b;
			exe_rd     <= id_rd;
			exe_wr_en  <= id_wr_en;	// Low for bubbles and x0
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// EXE/MEM and MEM/WB
	////////////////////////////////////////////////////////////////////////////

	// MEM does no work here; register kept for forwarding distance
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			mem_rd     <= '0;
			mem_wr_en  <= 1'b0;
			mem_result <= '0;
		end else begin
			mem_rd     <= exe_rd;
			mem_wr_en  <= exe_wr_en;
			mem_result <= exe_result;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wb_rd     <= '0;
			wb_wr_en  <= 1'b0;
			wb_result <= '0;
		end else begin
			wb_rd     <= mem_rd;
			wb_wr_en  <= mem_wr_en;
			wb_result <= mem_result;	// Register file write next edge
		end
	end

endmodule

`default_nettype wire

// File: verilog/rv_core.sv
////////////////////////////////////////////////////////////////////////////
// RV32I integer pipeline top
// Input register, ID, EXE, MEM and WB stages
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "rv_core_cfg.svh"

module rv_core import rv_core_pkg::*; (
	input  wire                     clk,
	input  wire                     arst_n,
	input  wire                     inst_valid,	// Instruction strobe
	input  wire [`RV_XLEN-1:0]      inst,
	output logic                    wb_valid,	// One pulse per register write
	output logic [`RV_REG_BITS-1:0] wb_rd,
	output logic [`RV_XLEN-1:0]     wb_data
);

	////////////////////////////////////////////////////////////////////////////
	// Stage signals
	////////////////////////////////////////////////////////////////////////////

	// ID
	rv_inst_t               id_inst;
	logic                   id_valid;
	logic [`RV_REG_BITS-1:0] id_rs1, id_rs2, id_rd;
	logic [`RV_XLEN-1:0]    id_imm;
	logic                   id_sel_imm;
	alu_op_e                id_alu_op;
	logic                   id_wr_en;
	logic [`RV_XLEN-1:0]    rf_data1, rf_data2;	// Register file reads
	logic [`RV_XLEN-1:0]    id_op_a, id_op_b;	// After forwarding

	// EXE
	alu_op_e                exe_alu_op;
	logic [`RV_XLEN-1:0]    exe_op_a, exe_op_b, exe_result;
	logic [`RV_REG_BITS-1:0] exe_rd;
	logic                   exe_wr_en;

	// MEM
	logic [`RV_REG_BITS-1:0] mem_rd;
	logic                   mem_wr_en;
	logic [`RV_XLEN-1:0]    mem_result;

	////////////////////////////////////////////////////////////////////////////
	// Instances
	////////////////////////////////////////////////////////////////////////////

	stage_regs stage_regs_inst (
		.clk(clk),               .arst_n(arst_n),
		.inst_valid(inst_valid), .inst(inst),
		.id_rd(id_rd),           .id_wr_en(id_wr_en),
		.id_alu_op(id_alu_op),   .id_op_a(id_op_a),
		.id_op_b(id_op_b),       .exe_result(exe_result),
		.id_inst(id_inst),       .id_valid(id_valid),
		.exe_alu_op(exe_alu_op), .exe_op_a(exe_op_a),
		.exe_op_b(exe_op_b),     .exe_rd(exe_rd),
		.exe_wr_en(exe_wr_en),   .mem_rd(mem_rd),
		.mem_wr_en(mem_wr_en),   .mem_result(mem_result),
		.wb_rd(wb_rd),           .wb_wr_en(wb_valid),	// MEM/WB drives outputs
		.wb_result(wb_data)
	);

	decoder decoder_inst (
		.id_inst(id_inst), .id_valid(id_valid),
		.rs1(id_rs1),      .rs2(id_rs2),         .rd(id_rd),
		.imm(id_imm),      .sel_imm(id_sel_imm),
		.alu_op(id_alu_op), .wr_en(id_wr_en)
	);

	regfile regfile_inst (
		.clk(clk),          .arst_n(arst_n),
		.rs1(id_rs1),       .rs2(id_rs2),
		.wr_en(wb_valid),   .wr_addr(wb_rd),  .wr_data(wb_data),
		.rd_data1(rf_data1), .rd_data2(rf_data2)
	);

	forward_unit forward_unit_inst (
		.rs1(id_rs1),           .rs2(id_rs2),
		.rf_data1(rf_data1),    .rf_data2(rf_data2),
		.imm(id_imm),           .sel_imm(id_sel_imm),
		.exe_rd(exe_rd),        .exe_wr_en(exe_wr_en), .exe_result(exe_result),
		.mem_rd(mem_rd),        .mem_wr_en(mem_wr_en), .mem_result(mem_result),
		.wb_rd(wb_rd),          .wb_wr_en(wb_valid),   .wb_result(wb_data),
		.op_a(id_op_a),         .op_b(id_op_b)
	);

	alu alu_inst (
		.op_a(exe_op_a), .op_b(exe_op_b),
		.alu_op(exe_alu_op),
		.result(exe_result)	// Also forwarded straight to ID
	);

endmodule

`default_nettype wire

// File: bench/tb_rv_core.sv
////////////////////////////////////////////////////////////////////////////
// Testbench for the RV32I integer pipeline
// Random instruction stream, reference model and writeback checker
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "rv_core_cfg.svh"

module tb_rv_core;

	localparam int NUM_INSTS     = 2000;	// Random instructions after the directed ones
	localparam int LATENCY       = 4;	// Drive cycle to writeback cycle
	localparam int DRAIN_TIMEOUT = 50;	// Cycles allowed for the last results

	logic                    clk;
	logic                    arst_n;
	logic                    inst_valid;
	logic [`RV_XLEN-1:0]     inst;
	logic                    wb_valid;
	logic [`RV_REG_BITS-1:0] wb_rd;
	logic [`RV_XLEN-1:0]     wb_data;

	integer seed;	// $random state
	int     cycle;	// Rising edges since start

	// Architectural state of the reference model
	logic [`RV_XLEN-1:0] model_regs [`RV_NUM_REGS];

	// Expected writebacks in program order
	logic [`RV_REG_BITS-1:0] exp_rd_q[$];
	logic [`RV_XLEN-1:0]     exp_data_q[$];
	int                      exp_cycle_q[$];

	rv_core rv_core_inst (
		.clk(clk),               .arst_n(arst_n),
		.inst_valid(inst_valid), .inst(inst),
		.wb_valid(wb_valid),     .wb_rd(wb_rd),   .wb_data(wb_data)
	);

	always #5 clk = ~clk;	// 10 ns period

	always @(posedge clk) begin
		cycle <= cycle + 1;
	end

	////////////////////////////////////////////////////////////////////////////
	// Reference model and instruction encoders
	////////////////////////////////////////////////////////////////////////////

	// RV32I semantics for OP, OP-IMM and LUI; anything else writes nothing
	function automatic logic ref_execute(input logic [31:0] word, output logic [4:0] rd,
			output logic [31:0] data);
		logic [6:0]  opcode;
		logic [2:0]  funct3;
		logic [31:0] a;
		logic [31:0] b;
		logic        writes;
		opcode = word[6:0];
		funct3 = word[14:12];
		rd     = word[11:7];
		a      = model_regs[word[19:15]];
		writes = 1'b1;
		data   = '0;
		if (opcode == 7'b0110111) begin
			data = {word[31:12], 12'h000};	// LUI
		end else if (opcode == 7'b0110011 || opcode == 7'b0010011) begin
			// Register operand or sign extended imm12
			b = (opcode == 7'b0110011) ? model_regs[word[24:20]] : {{20{word[31]}}, word[31:20]};
			case (funct3)
				3'd0: data = (opcode == 7'b0110011 && word[30]) ? a - b : a + b;
				3'd1: data = a << b[4:0];
				3'd2: data = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
				3'd3: data = (a < b) ? 32'd1 : 32'd0;
				3'd4: data = a ^ b;
				3'd5: begin
					if (word[30]) begin
						data = $signed(a) >>> b[4:0];	// SRA and SRAI
					end else begin
						data = a >> b[4:0];
					end
				end
				3'd6: data = a | b;
				default: data = a & b;
			endcase
		end else begin
			writes = 1'b0;	// Unsupported opcode
		end
		if (rd == 5'd0) begin
			writes = 1'b0;
		end
		if (writes) begin
			model_regs[rd] = data;
		end
		return writes;
	endfunction

	function automatic logic [31:0] enc_r(input logic [6:0] funct7, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] funct3, input logic [4:0] rd);
		return {funct7, rs2, rs1, funct3, rd, 7'b0110011};
	endfunction

	function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
			input logic [2:0] funct3, input logic [4:0] rd);
		return {imm, rs1, funct3, rd, 7'b0010011};
	endfunction

	function automatic logic [31:0] enc_lui(input logic [19:0] imm, input logic [4:0] rd);
		return {imm, rd, 7'b0110111};
	endfunction

	function automatic logic [31:0] rand32();
		return $random(seed);
	endfunction

	// Registers x0..x7 only, so dependencies at short distance are frequent
	function automatic logic [31:0] random_inst();
		logic [31:0] r;
		logic [4:0]  rd;
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		logic [2:0]  funct3;
		logic [11:0] imm;
		logic        alt;	// SUB or SRA variant
		r      = rand32();
		rd     = {2'b00, r[2:0]};
		rs1    = {2'b00, r[5:3]};
		rs2    = {2'b00, r[8:6]};
		funct3 = r[11:9];
		alt    = r[12];
		imm    = r[31:20];
		case (r[16:13])
			4'd0, 4'd1, 4'd2, 4'd3, 4'd4, 4'd5: begin
				return enc_r((alt && (funct3 == 3'd0 || funct3 == 3'd5)) ? 7'h20 : 7'h00,
					rs2, rs1, funct3, rd);
			end
			4'd12, 4'd13: return enc_lui(20'(rand32() >> 12), rd);
			4'd14: begin
				r = rand32();
				case (r[1:0])	// Load, store, branch and JAL opcodes
					2'd0: return {r[31:7], 7'b0000011};
					2'd1: return {r[31:7], 7'b0100011};
					2'd2: return {r[31:7], 7'b1100011};
					default: return {r[31:7], 7'b1101111};
				endcase
			end
			default: begin
				if (funct3 == 3'd1) begin
					imm = {7'h00, imm[4:0]};	// SLLI
				end else if (funct3 == 3'd5) begin
					imm = {1'b0, alt, 5'h00, imm[4:0]};	// SRLI or SRAI
				end
				return enc_i(imm, rs1, funct3, rd);
			end
		endcase
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Drive and check
	////////////////////////////////////////////////////////////////////////////

	task automatic check_value(input logic [31:0] got, input logic [31:0] expected,
			input string what);
		if (got !== expected) begin
			$display("Mismatch at %0t ns: %s is %h, expected %h", $time, what, got, expected);
			$display("Simulation failed");
			$fatal(1, "Value check failed");
		end
	endtask

	task automatic send_inst(input logic [31:0] word);
		logic [4:0]  rd;
		logic [31:0] data;
		@(posedge clk);
		#1;
		inst_valid = 1'b1;
		inst       = word;
		if (ref_execute(word, rd, data)) begin
			exp_rd_q.push_back(rd);
			exp_data_q.push_back(data);
			exp_cycle_q.push_back(cycle + LATENCY);
		end
	endtask

	task automatic idle_cycle();
		@(posedge clk);
		#1;
		inst_valid = 1'b0;
		inst       = rand32();	// Junk word must be ignored
	endtask

	// Outputs settle after the rising edge, so sample on the falling one
	always @(negedge clk) begin
		if (arst_n && wb_valid) begin
			if (exp_rd_q.size() == 0) begin
				$display("Writeback to x%0d at %0t ns with no instruction expecting it",
					wb_rd, $time);
				$display("Simulation failed");
				$fatal(1, "Unexpected writeback");
			end else begin
				check_value(32'(wb_rd), 32'(exp_rd_q.pop_front()), "wb_rd");
				check_value(wb_data, exp_data_q.pop_front(), "wb_data");
				check_value(cycle, exp_cycle_q.pop_front(), "writeback cycle");
			end
		end
	end

	initial begin
		int wait_cnt;
		clk        = 1'b0;
		arst_n     = 1'b0;
		inst_valid = 1'b0;
		inst       = '0;
		seed       = 32'he074;
		for (int i = 0; i < `RV_NUM_REGS; i++) begin
			model_regs[i] = '0;
		end
		repeat (10) @(posedge clk);
		#1;
		arst_n = 1'b1;

		// Dependent chain at distances 1, 2 and 3 with negative values
		send_inst(enc_lui(20'h80000, 5'd1));
		send_inst(enc_i(12'hfff, 5'd1, 3'd0, 5'd2));	// ADDI, EXE forward
		send_inst(enc_i(12'h404, 5'd1, 3'd5, 5'd3));	// SRAI, MEM forward
		send_inst(enc_r(7'h00, 5'd2, 5'd1, 3'd2, 5'd4));	// SLT, WB forward
		send_inst(enc_r(7'h00, 5'd2, 5'd1, 3'd3, 5'd5));	// SLTU
		send_inst(enc_i(12'h005, 5'd1, 3'd0, 5'd0));	// Write to x0
		idle_cycle();
		send_inst(enc_r(7'h20, 5'd3, 5'd0, 3'd0, 5'd6));	// x0 reads zero
		send_inst(enc_r(7'h20, 5'd4, 5'd1, 3'd5, 5'd7));	// SRA of negative

		for (int n = 0; n < NUM_INSTS; n++) begin
			if (rand32() % 8 == 0) begin
				idle_cycle();
			end
			send_inst(random_inst());
		end
		idle_cycle();

		wait_cnt = 0;
		while (exp_rd_q.size() != 0 && wait_cnt < DRAIN_TIMEOUT) begin
			@(posedge clk);
			wait_cnt++;
		end
		repeat (2 * LATENCY) idle_cycle();	// Room for stray writebacks
		if (exp_rd_q.size() != 0) begin
			$display("Timed out with %0d writebacks still missing", exp_rd_q.size());
			$display("Simulation failed");
			$fatal(1, "Writeback timeout");
		end else begin
			$display("Simulation completed successfully");
			$finish;
		end
	end

endmodule

`default_nettype wire

// File: sim.f
+incdir+verilog
verilog/rv_core_pkg.sv
verilog/decoder.sv
verilog/regfile.sv
verilog/forward_unit.sv
verilog/alu.sv
verilog/stage_regs.sv
verilog/rv_core.sv
bench/tb_rv_core.sv

// File: Makefile
# Verilator build and run of the RV32I pipeline testbench

VERILATOR := verilator
FLAGS     := --binary --timing --timescale 1ns/1ps
TOP       := tb_rv_core
FILELIST  := sim.f
OBJ_DIR   := obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

# The run exits with a failing status when the testbench stops with $fatal
test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
